// File: dv/mem_model.sv
// word memory with wait states
`timescale 1ns/1ps

module mem_model #(
	parameter logic [31:0] FILL = 32'hA5C3_0000
) (
	input logic CLK,
	input logic nRST,
	input logic dREN,
	input logic dWEN,
	input cache_geom_pkg::addr_t daddr,
	input cache_geom_pkg::word_t dstore,
	output logic dwait,
	output cache_geom_pkg::word_t dload,
	output int rd_count,
	output int wr_count
);
	localparam int DEPTH = 1024;

	cache_geom_pkg::word_t words [DEPTH];
	logic [9:0] widx;
	int seed;
	int wait_left; // wait cycles still owed to the current request

	function automatic int draw_wait();
		return $unsigned($random(seed)) % 4;
	endfunction

	assign widx = daddr[11:2];
	assign dwait = (dREN || dWEN) && (wait_left != 0);
	assign dload = words[widx];

	initial begin
		seed = 76482;
		for (int i = 0; i < DEPTH; i++)
			words[i] = FILL ^ i;
	end

	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			wait_left <= 0;
			rd_count <= 0;
			wr_count <= 0;
		end else if (dREN || dWEN) begin
			if (wait_left != 0) begin
				wait_left <= wait_left - 1;
			end else begin
				wait_left <= draw_wait(); // next transaction
				if (dWEN) begin
					words[widx] <= dstore;
					wr_count <= wr_count + 1;
				end else begin
					rd_count <= rd_count + 1;
				end
			end
		end
	end

endmodule

// File: dv/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic nRST
);
	localparam int RESET_CYCLES = 5;

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK; // 4 ns period
	end

	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
	end

endmodule

// File: dv/tb_dcache.sv
// data cache testbench
`timescale 1ns/1ps

module tb_dcache;

	localparam logic [31:0] FILL = 32'hA5C3_0000;
	localparam int MEM_WORDS = 1024;
	localparam int LIMIT = 200; // cycles allowed per wait
	localparam int QUIET_CYCLES = 20;
	localparam int FLUSH_WRITES = 4; // two dirty blocks left at halt

	typedef struct packed {
		logic wr;
		cache_geom_pkg::addr_t addr;
		cache_geom_pkg::word_t data;
		cache_geom_pkg::word_t load;
		logic [3:0] reads;
		logic [3:0] writes;
	} step_t;

	logic CLK, nRST;
	logic dmemREN, dmemWEN, halt;
	logic dhit, flushed, dwait, dREN, dWEN;
	cache_geom_pkg::addr_t dmemaddr, daddr;
	cache_geom_pkg::word_t dmemstore, dmemload, dload, dstore;
	int rd_count, wr_count;

	step_t steps [$];
	cache_geom_pkg::word_t shadow [MEM_WORDS]; // expected memory contents
	int errors;
	int checks;
	int timeouts;

	tb_clock clkgen (.CLK(CLK), .nRST(nRST));

	dcache dut (.CLK(CLK), .nRST(nRST), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
		.dmemaddr(dmemaddr), .dmemstore(dmemstore), .halt(halt), .dhit(dhit),
		.dmemload(dmemload), .flushed(flushed), .dwait(dwait), .dload(dload),
		.dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore));

	mem_model #(.FILL(FILL)) memory (.CLK(CLK), .nRST(nRST), .dREN(dREN), .dWEN(dWEN),
		.daddr(daddr), .dstore(dstore), .dwait(dwait), .dload(dload),
		.rd_count(rd_count), .wr_count(wr_count));

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic void add_step(input logic wr, input logic [31:0] addr,
		input logic [31:0] data, input logic [31:0] load, input int reads, input int writes);
		step_t s;
		s.wr = wr;
		s.addr = addr;
		s.data = data;
		s.load = load;
		s.reads = reads[3:0];
		s.writes = writes[3:0];
		steps.push_back(s);
	endfunction

	// op, address, store data, load, memory reads, memory writes
	function automatic void build_table();
		add_step(0, 'h048, 0, 'hA5C3_0012, 2, 0); // cold miss, set 1
		add_step(0, 'h04C, 0, 'hA5C3_0013, 0, 0);
		add_step(1, 'h04C, 'h1111_2222, 0, 0, 0);
		add_step(0, 'h04C, 0, 'h1111_2222, 0, 0);
		add_step(0, 'h088, 0, 'hA5C3_0022, 2, 0); // B into way 1
		add_step(0, 'h048, 0, 'hA5C3_0012, 0, 0);
		add_step(0, 'h0C8, 0, 'hA5C3_0032, 2, 0); // C replaces B
		add_step(0, 'h048, 0, 'hA5C3_0012, 0, 0);
		add_step(0, 'h088, 0, 'hA5C3_0022, 2, 0);
		add_step(1, 'h048, 'h3333_4444, 0, 0, 0);
		add_step(0, 'h0C8, 0, 'hA5C3_0032, 2, 0);
		add_step(0, 'h108, 0, 'hA5C3_0042, 2, 2); // dirty A evicted
		add_step(0, 'h048, 0, 'h3333_4444, 2, 0);
		add_step(0, 'h04C, 0, 'h1111_2222, 0, 0);
		add_step(1, 'h0A8, 'h5555_6666, 0, 2, 0); // write miss, set 5
		add_step(1, 'h0AC, 'h7777_8888, 0, 0, 0);
		add_step(1, 'h04C, 'h9999_AAAA, 0, 0, 0);
		add_step(0, 'h04C, 0, 'h9999_AAAA, 0, 0);
	endfunction

	// starts and ends on a falling edge
	task automatic run_step(input step_t s);
		int rd0;
		int wr0;
		int n;
		rd0 = rd_count;
		wr0 = wr_count;
		@(posedge CLK);
		dmemREN <= !s.wr;
		dmemWEN <= s.wr;
		dmemaddr <= s.addr;
		dmemstore <= s.data;
		n = 0;
		@(negedge CLK);
		while (!dhit && n < LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (!dhit) begin
			timeouts++;
			$display("no dhit within %0d cycles for address %h", LIMIT, s.addr);
		end else begin
			if (s.wr)
				shadow[s.addr[11:2]] = s.data;
			else
				check("dmemload", dmemload, s.load);
			check("memory reads", rd_count - rd0, s.reads);
			check("memory writes", wr_count - wr0, s.writes);
		end
		@(posedge CLK);
		dmemREN <= 1'b0;
		dmemWEN <= 1'b0;
		@(negedge CLK);
	endtask

	task automatic flush_and_compare();
		int n;
		int wr0;
		wr0 = wr_count;
		@(posedge CLK);
		halt <= 1'b1;
		n = 0;
		@(negedge CLK);
		while (!flushed && n < LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (!flushed) begin
			timeouts++;
			$display("flushed did not rise within %0d cycles of halt", LIMIT);
		end else begin
			check("flush writes", wr_count - wr0, FLUSH_WRITES);
			wr0 = wr_count;
			repeat (QUIET_CYCLES) @(negedge CLK);
			check("writes after flushed", wr_count - wr0, 0);
			check("flushed", flushed, 1'b1);
			for (int i = 0; i < MEM_WORDS; i++)
				check($sformatf("memory[%0d]", i), memory.words[i], shadow[i]);
		end
	endtask

	initial begin
		int n;
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		dmemaddr = '0;
		dmemstore = '0;
		halt = 1'b0;
		errors = 0;
		checks = 0;
		timeouts = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			shadow[i] = FILL ^ i;
		build_table();
		n = 0;
		while (nRST !== 1'b1 && n < LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (nRST !== 1'b1) begin
			timeouts++;
			$display("reset was never released");
		end else begin
			check("dhit", dhit, 1'b0);
			check("dREN", dREN, 1'b0);
			check("dWEN", dWEN, 1'b0);
			check("flushed", flushed, 1'b0);
		end
		foreach (steps[i]) begin
			if (timeouts == 0)
				run_step(steps[i]);
		end
		if (timeouts == 0)
			flush_and_compare();
		$display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: logic/cache_ctrl_pkg.sv
// cache controller types
package cache_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,   // waiting for a request or halt
		LOOKUP, // tag compare, hit answered here
		WB0,    // victim word 0 to memory
		WB1,
		FILL0,  // block fetch, word 0 first
		FILL1,
		FLUSH,  // port owned by the walker
		DONE
	} ctrl_state_t;

	typedef logic way_t;

endpackage

// File: logic/cache_geom_pkg.sv
// cache geometry
package cache_geom_pkg;

	localparam int NUM_SETS = 8;
	localparam int NUM_WAYS = 2;
	localparam int WORDS_PER_BLOCK = 2;
	localparam int IDX_W = 3;
	localparam int TAG_W = 26;

	// byte address split:
	// [31:6] tag, [5:3] index, [2] word in block, [1:0] always zero

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [IDX_W-1:0] idx_t;

	// word select within a block
	typedef logic blkoff_t;

endpackage

// File: logic/dcache.sv
// data cache top
`timescale 1ns/1ps

module dcache (
	input logic CLK,
	input logic nRST,
	input logic dmemREN,
	input logic dmemWEN,
	input cache_geom_pkg::addr_t dmemaddr,
	input cache_geom_pkg::word_t dmemstore,
	input logic halt,
	output logic dhit,
	output cache_geom_pkg::word_t dmemload,
	output logic flushed,
	input logic dwait,
	input cache_geom_pkg::word_t dload,
	output logic dREN,
	output logic dWEN,
	output cache_geom_pkg::addr_t daddr,
	output cache_geom_pkg::word_t dstore
);
	logic hit, victim_dirty;
	cache_ctrl_pkg::way_t hit_way, victim_way;
	cache_geom_pkg::word_t rd_data;
	cache_geom_pkg::tag_t victim_tag;

	// store write strobes
	logic wr_en, set_tag, set_valid, set_dirty, clr_dirty, touch;
	cache_ctrl_pkg::way_t wr_way, touch_way;
	cache_geom_pkg::blkoff_t wr_off;
	cache_geom_pkg::word_t wr_data;

	// walker side
	logic flush_grant, flush_req, flush_valid_dirty;
	cache_geom_pkg::idx_t flush_idx;
	cache_ctrl_pkg::way_t flush_way;
	cache_geom_pkg::addr_t flush_addr;
	cache_geom_pkg::word_t flush_data, flush_word0, flush_word1;
	cache_geom_pkg::tag_t flush_tag;

	dcache_store store (.CLK, .nRST, .addr(dmemaddr), .wr_en, .wr_way, .wr_off, .wr_data,
		.set_tag, .set_valid, .set_dirty, .clr_dirty, .touch, .touch_way, .flush_idx, .flush_way,
		.hit, .hit_way, .rd_data, .victim_way, .victim_dirty, .victim_tag, .flush_valid_dirty,
		.flush_tag, .flush_word0, .flush_word1);

	dcache_ctrl ctrl (.CLK, .nRST, .dmemREN, .dmemWEN, .dmemaddr, .dmemstore, .halt, .dhit,
		.dmemload, .dwait, .dload, .dREN, .dWEN, .daddr, .dstore, .hit, .hit_way, .rd_data,
		.victim_way, .victim_dirty, .victim_tag, .wr_en, .wr_way, .wr_off, .wr_data, .set_tag,
		.set_valid, .set_dirty, .clr_dirty, .touch, .touch_way, .flush_req, .flush_addr,
		.flush_data, .flushed, .flush_grant);

	dcache_flush walker (.CLK, .nRST, .flush_grant, .dwait, .flush_valid_dirty, .flush_tag,
		.flush_word0, .flush_word1, .flush_idx, .flush_way, .flush_req, .flush_addr,
		.flush_data, .flushed);

endmodule

// File: logic/dcache_ctrl.sv
// cache miss controller
`timescale 1ns/1ps

module dcache_ctrl (
	input logic CLK,
	input logic nRST,
	input logic dmemREN,
	input logic dmemWEN,
	input cache_geom_pkg::addr_t dmemaddr,
	input cache_geom_pkg::word_t dmemstore,
	input logic halt,
	output logic dhit,
	output cache_geom_pkg::word_t dmemload,
	input logic dwait,
	input cache_geom_pkg::word_t dload,
	output logic dREN,
	output logic dWEN,
	output cache_geom_pkg::addr_t daddr,
	output cache_geom_pkg::word_t dstore,
	input logic hit,
	input cache_ctrl_pkg::way_t hit_way,
	input cache_geom_pkg::word_t rd_data,
	input cache_ctrl_pkg::way_t victim_way,
	input logic victim_dirty,
	input cache_geom_pkg::tag_t victim_tag,
	output logic wr_en,
	output cache_ctrl_pkg::way_t wr_way,
	output cache_geom_pkg::blkoff_t wr_off,
	output cache_geom_pkg::word_t wr_data,
	output logic set_tag,
	output logic set_valid,
	output logic set_dirty,
	output logic clr_dirty,
	output logic touch,
	output cache_ctrl_pkg::way_t touch_way,
	input logic flush_req,
	input cache_geom_pkg::addr_t flush_addr,
	input cache_geom_pkg::word_t flush_data,
	input logic flushed,
	output logic flush_grant
);
	cache_ctrl_pkg::ctrl_state_t state, next_state;
	cache_geom_pkg::tag_t req_tag;
	cache_geom_pkg::idx_t req_idx;
	cache_geom_pkg::blkoff_t req_off;

	assign req_tag = dmemaddr[31 -: cache_geom_pkg::TAG_W];
	assign req_idx = dmemaddr[3 +: cache_geom_pkg::IDX_W];
	assign req_off = dmemaddr[2];

	assign dmemload = rd_data; // taken while dhit is high

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			state <= cache_ctrl_pkg::IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		dhit = 1'b0;
		dREN = 1'b0;
		dWEN = 1'b0;
		daddr = '0;
		dstore = rd_data;
		wr_en = 1'b0;
		wr_way = victim_way;
		wr_off = req_off;
		wr_data = dmemstore;
		set_tag = 1'b0;
		set_valid = 1'b0;
		set_dirty = 1'b0;
		clr_dirty = 1'b0;
		touch = 1'b0;
		touch_way = victim_way;
		flush_grant = 1'b0;
		case (state)
			cache_ctrl_pkg::IDLE: begin
				if (halt)
					next_state = cache_ctrl_pkg::FLUSH;
				else if (dmemREN || dmemWEN)
					next_state = cache_ctrl_pkg::LOOKUP;
			end
			cache_ctrl_pkg::LOOKUP: begin
				if (hit) begin
					dhit = 1'b1;
					touch = 1'b1;
					touch_way = hit_way;
					wr_way = hit_way;
					wr_en = dmemWEN;
					set_dirty = dmemWEN;
					next_state = cache_ctrl_pkg::IDLE;
				end else if (victim_dirty) begin
					next_state = cache_ctrl_pkg::WB0;
				end else begin
					next_state = cache_ctrl_pkg::FILL0;
				end
			end
			cache_ctrl_pkg::WB0: begin
				dWEN = 1'b1;
				wr_off = 1'b0; // selects victim word for dstore
				daddr = {victim_tag, req_idx, 1'b0, 2'b00};
				if (!dwait)
					next_state = cache_ctrl_pkg::WB1;
			end
			cache_ctrl_pkg::WB1: begin
				dWEN = 1'b1;
				wr_off = 1'b1;
				daddr = {victim_tag, req_idx, 1'b1, 2'b00};
				if (!dwait)
					next_state = cache_ctrl_pkg::FILL0;
			end
			cache_ctrl_pkg::FILL0: begin
				dREN = 1'b1;
				wr_off = 1'b0;
				wr_data = dload;
				wr_en = !dwait;
				daddr = {req_tag, req_idx, 1'b0, 2'b00};
				if (!dwait)
					next_state = cache_ctrl_pkg::FILL1;
			end
			cache_ctrl_pkg::FILL1: begin
				dREN = 1'b1;
				wr_off = 1'b1;
				wr_data = dload;
				daddr = {req_tag, req_idx, 1'b1, 2'b00};
				if (!dwait) begin
					wr_en = 1'b1;
					set_tag = 1'b1;
					set_valid = 1'b1;
					clr_dirty = 1'b1;
					touch = 1'b1;
					next_state = cache_ctrl_pkg::LOOKUP; // replays as a hit
				end
			end
			cache_ctrl_pkg::FLUSH: begin
				flush_grant = 1'b1;
				dWEN = flush_req;
				daddr = flush_addr;
				dstore = flush_data;
				if (flushed)
					next_state = cache_ctrl_pkg::DONE;
			end
			cache_ctrl_pkg::DONE: begin
				next_state = cache_ctrl_pkg::DONE; // quiet until reset
			end
			default: next_state = cache_ctrl_pkg::IDLE;
		endcase
	end

endmodule

// File: logic/dcache_flush.sv
// halt flush walker
`timescale 1ns/1ps

module dcache_flush (
	input logic CLK,
	input logic nRST,
	input logic flush_grant,
	input logic dwait,
	input logic flush_valid_dirty,
	input cache_geom_pkg::tag_t flush_tag,
	input cache_geom_pkg::word_t flush_word0,
	input cache_geom_pkg::word_t flush_word1,
	output cache_geom_pkg::idx_t flush_idx,
	output cache_ctrl_pkg::way_t flush_way,
	output logic flush_req,
	output cache_geom_pkg::addr_t flush_addr,
	output cache_geom_pkg::word_t flush_data,
	output logic flushed
);
	cache_geom_pkg::blkoff_t word_sel;
	logic active;
	logic last_set;
	logic step;

	assign active = flush_grant && !flushed;
	assign last_set = (flush_idx == cache_geom_pkg::idx_t'(cache_geom_pkg::NUM_SETS - 1));

	assign flush_req = active && flush_valid_dirty;
	assign flush_addr = {flush_tag, flush_idx, word_sel, 2'b00};
	assign flush_data = word_sel ? flush_word1 : flush_word0;

	// clean blocks skip at once, dirty ones after word 1 is accepted
	assign step = active && (!flush_valid_dirty || (word_sel && !dwait));

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			flush_idx <= '0;
			flush_way <= '0;
			word_sel <= 1'b0;
			flushed <= 1'b0;
		end else begin
			if (flush_req && !dwait)
				word_sel <= ~word_sel;
			if (step) begin
				if (last_set) begin
					flush_idx <= '0;
					if (flush_way == cache_ctrl_pkg::way_t'(cache_geom_pkg::NUM_WAYS - 1))
						flushed <= 1'b1; // sticky
					else
						flush_way <= flush_way + 1'b1;
				end else begin
					flush_idx <= flush_idx + 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/dcache_store.sv
// cache arrays and lookup
`timescale 1ns/1ps

module dcache_store (
	input logic CLK,
	input logic nRST,
	input cache_geom_pkg::addr_t addr,
	input logic wr_en,
	input cache_ctrl_pkg::way_t wr_way,
	input cache_geom_pkg::blkoff_t wr_off, // word select for both read and write
	input cache_geom_pkg::word_t wr_data,
	input logic set_tag,
	input logic set_valid,
	input logic set_dirty,
	input logic clr_dirty,
	input logic touch,
	input cache_ctrl_pkg::way_t touch_way,
	input cache_geom_pkg::idx_t flush_idx,
	input cache_ctrl_pkg::way_t flush_way,
	output logic hit,
	output cache_ctrl_pkg::way_t hit_way,
	output cache_geom_pkg::word_t rd_data,
	output cache_ctrl_pkg::way_t victim_way,
	output logic victim_dirty,
	output cache_geom_pkg::tag_t victim_tag,
	output logic flush_valid_dirty,
	output cache_geom_pkg::tag_t flush_tag,
	output cache_geom_pkg::word_t flush_word0,
	output cache_geom_pkg::word_t flush_word1
);
	cache_geom_pkg::tag_t a_tag;
	cache_geom_pkg::idx_t a_idx;
	cache_ctrl_pkg::way_t rd_way;

	cache_geom_pkg::tag_t tags [cache_geom_pkg::NUM_WAYS][cache_geom_pkg::NUM_SETS];
	cache_geom_pkg::word_t data [cache_geom_pkg::NUM_WAYS][cache_geom_pkg::NUM_SETS]
		[cache_geom_pkg::WORDS_PER_BLOCK];

	logic [cache_geom_pkg::NUM_WAYS-1:0][cache_geom_pkg::NUM_SETS-1:0] valid;
	logic [cache_geom_pkg::NUM_WAYS-1:0][cache_geom_pkg::NUM_SETS-1:0] dirty;
	logic [cache_geom_pkg::NUM_SETS-1:0] lru; // least recent way per set
	logic [cache_geom_pkg::NUM_WAYS-1:0] way_hit;

	assign a_tag = addr[31 -: cache_geom_pkg::TAG_W];
	assign a_idx = addr[3 +: cache_geom_pkg::IDX_W];

	always_comb begin
		for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
			way_hit[w] = valid[w][a_idx] && (tags[w][a_idx] == a_tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];

	// fill an empty way before evicting
	always_comb begin
		if (!valid[0][a_idx]) begin
			victim_way = 1'b0;
		end else if (!valid[1][a_idx]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru[a_idx];
		end
	end

	assign victim_dirty = valid[victim_way][a_idx] && dirty[victim_way][a_idx];
	assign victim_tag = tags[victim_way][a_idx];

	assign rd_way = hit ? hit_way : victim_way; // victim data feeds write-back
	assign rd_data = data[rd_way][a_idx][wr_off];

	// walker read port
	assign flush_valid_dirty = valid[flush_way][flush_idx] && dirty[flush_way][flush_idx];
	assign flush_tag = tags[flush_way][flush_idx];
	assign flush_word0 = data[flush_way][flush_idx][0];
	assign flush_word1 = data[flush_way][flush_idx][1];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else begin
			if (set_valid)
				valid[wr_way][a_idx] <= 1'b1;
			if (set_dirty)
				dirty[wr_way][a_idx] <= 1'b1;
			else if (clr_dirty)
				dirty[wr_way][a_idx] <= 1'b0;
			if (touch)
				lru[a_idx] <= ~touch_way; // other way becomes least recent
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en)
			data[wr_way][a_idx][wr_off] <= wr_data;
		if (set_tag)
			tags[wr_way][a_idx] <= a_tag;
	end

endmodule

// File: sources.f
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/dcache_store.sv
logic/dcache_ctrl.sv
logic/dcache_flush.sv
logic/dcache.sv
dv/tb_clock.sv
dv/mem_model.sv
dv/tb_dcache.sv
